/* rtl/video_pkg.sv */
package video_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Raster defaults, PAL-like
   ////////////////////////////////////////////////////////////////////////////

   // Horizontal, in source pixels
   localparam int H_ACTIVE_DEF = 256;
   localparam int H_TOTAL_DEF  = 448;
   localparam int H_SYNC_DEF   = 32;

   // Vertical, in lines
   localparam int V_ACTIVE_DEF = 192;
   localparam int V_TOTAL_DEF  = 312;
   localparam int V_SYNC_DEF   = 4;

   // Both syncs are low-active
   localparam logic SYNC_ACTIVE = 1'b0;

   ////////////////////////////////////////////////////////////////////////////
   // Pixel colour
   ////////////////////////////////////////////////////////////////////////////

   // 3 bits per channel, 9-bit pixel
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [2:0] b;
   } rgb_t;

endpackage

/* rtl/board_pkg.sv */
package board_pkg;

   // System clocks per source pixel
   // VGA pixels run at twice this rate, so keep it even
   localparam int PIX_DIV_DEF = 4;

   // Width of the LED monostable counter
   // 22 bits gives roughly a tenth of a second at 28 MHz
   localparam int LED_STRETCH_DEF = 22;

   // Video encoder standard pins
   // stdn low selects PAL
   localparam logic STDN_PAL  = 1'b0;
   // stdnb high routes the PAL subcarrier clock
   localparam logic STDNB_PAL = 1'b1;

endpackage

/* rtl/video_if.sv */
`timescale 1ns/1ps

interface video_if;

   import video_pkg::*;

   // Pixel strobe, one cycle per new pixel
   logic pix_en;
   // Pixel colour, held between strobes
   rgb_t rgb;
   // Low-active syncs
   logic hsync_n;
   logic vsync_n;

   // Video generator side
   modport source (output pix_en, rgb, hsync_n, vsync_n);

   // Consumer side, e.g. the scandoubler
   modport sink (input pix_en, rgb, hsync_n, vsync_n);

endinterface

/* rtl/clock_enables.sv */
`timescale 1ns/1ps

module clock_enables #(
   parameter int PIX_DIV = board_pkg::PIX_DIV_DEF
) (
   input  logic sysclk,
   input  logic reset,
   output logic ce_pix,
   output logic ce_vga
);

   // Half period, in system clocks, of the VGA pixel
   localparam int HALF = PIX_DIV / 2;
   localparam int CW   = $clog2(PIX_DIV);

   logic [CW-1:0] div_cnt;

   // Free-running modulo-PIX_DIV phase counter
   always_ff @(posedge sysclk) begin
      if (reset) begin
         div_cnt <= '0;
      end else if (div_cnt == CW'(PIX_DIV - 1)) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // Source pixel strobe, mid-period
   assign ce_pix = (div_cnt == CW'(HALF - 1));

   // VGA strobe at twice the rate
   // one of its two phases lines up with ce_pix
   assign ce_vga = ce_pix || (div_cnt == CW'(PIX_DIV - 1));

endmodule

/* rtl/pal_video_source.sv */
`timescale 1ns/1ps

module pal_video_source #(
   parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
   parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
   parameter int H_SYNC   = video_pkg::H_SYNC_DEF,
   parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
   parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF,
   parameter int V_SYNC   = video_pkg::V_SYNC_DEF
) (
   input  logic    sysclk,
   input  logic    reset,
   input  logic    ce_pix,
   video_if.source vid
);

   import video_pkg::*;

   // Counters wide enough for the pattern bits as well
   localparam int HW = ($clog2(H_TOTAL) > 6) ? $clog2(H_TOTAL) : 6;
   localparam int VW = ($clog2(V_TOTAL) > 3) ? $clog2(V_TOTAL) : 3;

   // Sync start positions, wrapped into the raster
   localparam int HS_START = (H_ACTIVE + 8) % H_TOTAL;
   localparam int VS_START = (V_ACTIVE + 2) % V_TOTAL;

   logic [HW-1:0] hcnt;
   logic [VW-1:0] vcnt;
   logic [HW-1:0] hs_off;
   logic [VW-1:0] vs_off;
   logic          h_last;
   logic          active;
   logic          hs_on;
   logic          vs_on;
   rgb_t          pattern;

   assign h_last = (hcnt == HW'(H_TOTAL - 1));

   // Raster counters, one step per source pixel
   always_ff @(posedge sysclk) begin
      if (reset) begin
         hcnt <= '0;
         vcnt <= '0;
      end else if (ce_pix) begin
         if (h_last) begin
            hcnt <= '0;
            if (vcnt == VW'(V_TOTAL - 1)) begin
               vcnt <= '0;
            end else begin
               vcnt <= vcnt + 1'b1;
            end
         end else begin
            hcnt <= hcnt + 1'b1;
         end
      end
   end

   // Distance past the sync start, modulo the raster size
   assign hs_off = (hcnt >= HW'(HS_START)) ? hcnt - HW'(HS_START)
                                           : hcnt + HW'(H_TOTAL - HS_START);
   assign vs_off = (vcnt >= VW'(VS_START)) ? vcnt - VW'(VS_START)
                                           : vcnt + VW'(V_TOTAL - VS_START);

   assign hs_on  = (hs_off < HW'(H_SYNC));
   assign vs_on  = (vs_off < VW'(V_SYNC));
   assign active = (hcnt < HW'(H_ACTIVE)) && (vcnt < VW'(V_ACTIVE));

   // Column/line colour pattern
   assign pattern.r = hcnt[2:0];
   assign pattern.g = vcnt[2:0];
   assign pattern.b = hcnt[5:3];

   // Registered outputs, valid the cycle after ce_pix
   always_ff @(posedge sysclk) begin
      if (reset) begin
         vid.pix_en  <= 1'b0;
         vid.rgb     <= '0;
         vid.hsync_n <= ~SYNC_ACTIVE;
         vid.vsync_n <= ~SYNC_ACTIVE;
      end else begin
         vid.pix_en <= ce_pix;
         if (ce_pix) begin
            // Border and blanking are black
            vid.rgb     <= active ? pattern : '0;
            vid.hsync_n <= hs_on ? SYNC_ACTIVE : ~SYNC_ACTIVE;
            vid.vsync_n <= vs_on ? SYNC_ACTIVE : ~SYNC_ACTIVE;
         end
      end
   end

endmodule

/* rtl/vga_scandoubler.sv */
`timescale 1ns/1ps

module vga_scandoubler #(
   parameter int H_TOTAL = video_pkg::H_TOTAL_DEF,
   parameter int H_SYNC  = video_pkg::H_SYNC_DEF
) (
   input  logic       sysclk,
   input  logic       reset,
   input  logic       ce_vga,
   input  logic       enable_scandoubling,
   input  logic       disable_scaneffect,
   video_if.sink      src,
   output logic [2:0] ro,
   output logic [2:0] go,
   output logic [2:0] bo,
   output logic       hsync,
   output logic       vsync
);

   import video_pkg::*;

   localparam int AW = $clog2(H_TOTAL);

   // Two line halves, selected by the top address bit
   rgb_t line_mem [0:(2**(AW+1))-1];

   logic          hs_prev;
   logic          hs_fall;
   logic          wsel;
   logic [AW-1:0] wptr;
   logic          wr_half;
   logic [AW-1:0] wr_addr;
   logic          ce_rd;
   logic [AW-1:0] rptr;
   logic          second_pass;
   logic          line_seen;
   logic          rd_run;
   logic          vs_cur;
   logic          vs_rd;
   rgb_t          rd_pix;
   rgb_t          dbl_pix;

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////

   // Source line boundary
   assign hs_fall = (hs_prev != SYNC_ACTIVE) && (src.hsync_n == SYNC_ACTIVE);

   // The pixel arriving with the sync edge opens the new half at address 0
   assign wr_half = hs_fall ? ~wsel : wsel;
   assign wr_addr = hs_fall ? '0 : wptr;

   always_ff @(posedge sysclk) begin
      if (reset) begin
         hs_prev <= ~SYNC_ACTIVE;
         wsel    <= 1'b0;
         wptr    <= '0;
      end else begin
         hs_prev <= src.hsync_n;
         wsel    <= wr_half;
         wptr    <= wr_addr + AW'(src.pix_en);
      end
   end

   always_ff @(posedge sysclk) begin
      if (src.pix_en) begin
         line_mem[{wr_half, wr_addr}] <= src.rgb;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read side, two passes per source line
   ////////////////////////////////////////////////////////////////////////////

   // Read strobe lags ce_vga by one cycle
   // to line up with the registered source
   always_ff @(posedge sysclk) begin
      if (reset) begin
         ce_rd       <= 1'b0;
         rptr        <= '0;
         second_pass <= 1'b0;
         line_seen   <= 1'b0;
         rd_run      <= 1'b0;
         vs_cur      <= ~SYNC_ACTIVE;
         vs_rd       <= ~SYNC_ACTIVE;
      end else begin
         ce_rd <= ce_vga;
         if (hs_fall) begin
            rptr        <= '0;
            second_pass <= 1'b0;
            // Start replaying once a whole line is stored
            line_seen   <= 1'b1;
            rd_run      <= line_seen;
            // Vsync follows its line into the readout
            vs_cur      <= src.vsync_n;
            vs_rd       <= vs_cur;
         end else if (ce_rd) begin
            if (rptr == AW'(H_TOTAL - 1)) begin
               rptr        <= '0;
               second_pass <= 1'b1;
            end else begin
               rptr <= rptr + 1'b1;
            end
         end
      end
   end

   // Half not being written holds the previous line
   assign rd_pix = line_mem[{~wsel, rptr}];

   // Scanline effect, repeat pass at half intensity
   always_comb begin
      dbl_pix = rd_pix;
      if (second_pass && !disable_scaneffect) begin
         dbl_pix.r = rd_pix.r >> 1;
         dbl_pix.g = rd_pix.g >> 1;
         dbl_pix.b = rd_pix.b >> 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output register, doubled or bypass
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge sysclk) begin
      if (reset) begin
         ro    <= '0;
         go    <= '0;
         bo    <= '0;
         hsync <= ~SYNC_ACTIVE;
         vsync <= ~SYNC_ACTIVE;
      end else if (enable_scandoubling) begin
         // Black and no sync until the first full line is stored
         ro    <= rd_run ? dbl_pix.r : 3'd0;
         go    <= rd_run ? dbl_pix.g : 3'd0;
         bo    <= rd_run ? dbl_pix.b : 3'd0;
         // VGA hsync regenerated at the start of every pass
         hsync <= (rd_run && (rptr < AW'(H_SYNC))) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
         vsync <= vs_rd;
      end else begin
         // 15 kHz passthrough
         ro    <= src.rgb.r;
         go    <= src.rgb.g;
         bo    <= src.rgb.b;
         hsync <= src.hsync_n;
         vsync <= src.vsync_n;
      end
   end

endmodule

/* rtl/activity_led.sv */
`timescale 1ns/1ps

module activity_led #(
   parameter int LED_STRETCH = board_pkg::LED_STRETCH_DEF
) (
   input  logic sysclk,
   input  logic reset,
   input  logic flash_cs_n,
   input  logic sd_cs_n,
   output logic testled
);

   // Top bit set means the stretch has run out
   logic [LED_STRETCH:0] mono;
   logic                 busy;

   // Any select low counts as SPI activity
   assign busy = !flash_cs_n || !sd_cs_n;

   // Retriggerable monostable
   always_ff @(posedge sysclk) begin
      if (reset) begin
         // Start expired, LED off
         mono <= {1'b1, {LED_STRETCH{1'b0}}};
      end else if (busy) begin
         mono <= '0;
      end else if (!mono[LED_STRETCH]) begin
         mono <= mono + 1'b1;
      end
   end

   // Lit until the counter reaches 2^LED_STRETCH
   assign testled = ~mono[LED_STRETCH];

endmodule

/* rtl/tld_zxuno.sv */
`timescale 1ns/1ps

module tld_zxuno #(
   parameter int H_ACTIVE    = video_pkg::H_ACTIVE_DEF,
   parameter int H_TOTAL     = video_pkg::H_TOTAL_DEF,
   parameter int H_SYNC      = video_pkg::H_SYNC_DEF,
   parameter int V_ACTIVE    = video_pkg::V_ACTIVE_DEF,
   parameter int V_TOTAL     = video_pkg::V_TOTAL_DEF,
   parameter int V_SYNC      = video_pkg::V_SYNC_DEF,
   parameter int PIX_DIV     = board_pkg::PIX_DIV_DEF,
   parameter int LED_STRETCH = board_pkg::LED_STRETCH_DEF
) (
   input  logic       sysclk,
   input  logic       reset,
   input  logic       vga_enable,
   input  logic       scanlines_enable,
   input  logic       flash_cs_n,
   input  logic       sd_cs_n,
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b,
   output logic       hsync,
   output logic       vsync,
   output logic       stdn,
   output logic       stdnb,
   output logic       testled
);

   import board_pkg::*;

   logic ce_pix;
   logic ce_vga;

   // PAL-rate pixel stream into the scandoubler
   video_if pal_video ();

   ////////////////////////////////////////////////////////////////////////////
   // Video path
   ////////////////////////////////////////////////////////////////////////////

   // Pixel strobes stand in for the board's derived clocks
   clock_enables #(
      .PIX_DIV (PIX_DIV)
   ) u_clock_enables (
      .sysclk (sysclk),
      .reset  (reset),
      .ce_pix (ce_pix),
      .ce_vga (ce_vga)
   );

   pal_video_source #(
      .H_ACTIVE (H_ACTIVE),
      .H_TOTAL  (H_TOTAL),
      .H_SYNC   (H_SYNC),
      .V_ACTIVE (V_ACTIVE),
      .V_TOTAL  (V_TOTAL),
      .V_SYNC   (V_SYNC)
   ) u_pal_video_source (
      .sysclk (sysclk),
      .reset  (reset),
      .ce_pix (ce_pix),
      .vid    (pal_video.source)
   );

   vga_scandoubler #(
      .H_TOTAL (H_TOTAL),
      .H_SYNC  (H_SYNC)
   ) u_vga_scandoubler (
      .sysclk              (sysclk),
      .reset               (reset),
      .ce_vga              (ce_vga),
      .enable_scandoubling (vga_enable),
      // Scanlines switch is active high at the board
      .disable_scaneffect  (~scanlines_enable),
      .src                 (pal_video.sink),
      .ro                  (r),
      .go                  (g),
      .bo                  (b),
      .hsync               (hsync),
      .vsync               (vsync)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Board odds and ends
   ////////////////////////////////////////////////////////////////////////////

   // SPI activity indicator
   activity_led #(
      .LED_STRETCH (LED_STRETCH)
   ) u_activity_led (
      .sysclk     (sysclk),
      .reset      (reset),
      .flash_cs_n (flash_cs_n),
      .sd_cs_n    (sd_cs_n),
      .testled    (testled)
   );

   // Encoder fixed to PAL
   assign stdn  = STDN_PAL;
   assign stdnb = STDNB_PAL;

endmodule

/* verification/tb_tld_zxuno.sv */
`timescale 1ns/1ps

module tb_tld_zxuno;

   ///////////////////////////////////////////////////////////////////////////
   // Small raster and derived reference timing
   ///////////////////////////////////////////////////////////////////////////

   localparam int H_ACTIVE    = 16;
   localparam int H_TOTAL     = 24;
   localparam int H_SYNC      = 2;
   localparam int V_ACTIVE    = 6;
   localparam int V_TOTAL     = 10;
   localparam int V_SYNC      = 1;
   localparam int PIX_DIV     = 4;
   localparam int LED_STRETCH = 4;

   localparam int LINE_CYCLES  = H_TOTAL * PIX_DIV;
   localparam int FRAME_CYCLES = LINE_CYCLES * V_TOTAL;
   // Column shown at each hsync fall, line shown at each vsync fall
   localparam int HS_COL       = (H_ACTIVE + 8) % H_TOTAL;
   localparam int VS_LINE      = (V_ACTIVE + 2) % V_TOTAL;
   localparam int LED_TIME     = 2 ** LED_STRETCH;
   localparam int IDLE_MAX     = LED_TIME * 4;

   logic       sysclk;
   logic       reset;
   logic       vga_enable;
   logic       scanlines_enable;
   logic       flash_cs_n;
   logic       sd_cs_n;
   logic [2:0] r;
   logic [2:0] g;
   logic [2:0] b;
   logic       hsync;
   logic       vsync;
   logic       stdn;
   logic       stdnb;
   logic       testled;

   // Reference state, owned by the checker block
   logic        checks_on = 1'b0;
   logic        reset_d   = 1'b0;
   logic        hs_q      = 1'b1;
   logic        vs_q      = 1'b1;
   logic        h_armed   = 1'b0;
   logic        hl_armed  = 1'b0;
   logic        v_armed   = 1'b0;
   logic        vl_armed  = 1'b0;
   logic        locked    = 1'b0;
   int          hper      = 0;
   int          hlow      = 0;
   int          vper      = 0;
   int          vlow      = 0;
   int          cyc       = 0;
   int          line      = 0;
   int          pass      = 0;
   int          idle_cnt  = IDLE_MAX;
   int          pixel_checks = 0;
   logic [15:0] lfsr      = 16'd63465;

   tld_zxuno #(
      .H_ACTIVE    (H_ACTIVE),
      .H_TOTAL     (H_TOTAL),
      .H_SYNC      (H_SYNC),
      .V_ACTIVE    (V_ACTIVE),
      .V_TOTAL     (V_TOTAL),
      .V_SYNC      (V_SYNC),
      .PIX_DIV     (PIX_DIV),
      .LED_STRETCH (LED_STRETCH)
   ) dut (
      .sysclk           (sysclk),
      .reset            (reset),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .flash_cs_n       (flash_cs_n),
      .sd_cs_n          (sd_cs_n),
      .r                (r),
      .g                (g),
      .b                (b),
      .hsync            (hsync),
      .vsync            (vsync),
      .stdn             (stdn),
      .stdnb            (stdnb),
      .testled          (testled)
   );

   initial begin
      sysclk = 1'b0;
      forever #5 sysclk = ~sysclk;
   end

   ///////////////////////////////////////////////////////////////////////////
   // Error reporting and helpers
   ///////////////////////////////////////////////////////////////////////////

   task automatic stop_on_error();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic fail_value(input string test, input int expected, input int actual);
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", test, expected, actual);
      stop_on_error();
   endtask

   task automatic fail_text(input string msg);
      $display("ERROR: %s", msg);
      stop_on_error();
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic random_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   // Column/line pattern, black outside the active area
   function automatic logic [8:0] expected_pixel(input int col, input int row, input bit dim);
      logic [2:0] pr;
      logic [2:0] pg;
      logic [2:0] pb;
      pr = '0;
      pg = '0;
      pb = '0;
      if (col < H_ACTIVE && row < V_ACTIVE) begin
         pr = 3'(col % 8);
         pg = 3'(row % 8);
         pb = 3'((col / 8) % 8);
      end
      // Scanline pass at half intensity
      if (dim) begin
         pr = pr >> 1;
         pg = pg >> 1;
         pb = pb >> 1;
      end
      return {pr, pg, pb};
   endfunction

   task automatic wait_vsync_falls(input int count);
      int   seen;
      int   cycles;
      logic prev;
      seen   = 0;
      cycles = 0;
      prev   = vsync;
      while (seen < count) begin
         @(posedge sysclk);
         cycles++;
         if (prev && !vsync) begin
            seen++;
         end
         prev = vsync;
         if (cycles > (count + 1) * FRAME_CYCLES * 2) begin
            fail_text("vsync stopped falling");
         end
      end
   endtask

   task automatic wait_led_off();
      int cycles;
      cycles = 0;
      while (testled) begin
         @(posedge sysclk);
         cycles++;
         if (cycles > IDLE_MAX) begin
            fail_text("activity LED never went dark");
         end
      end
   endtask

   // Mode 0 bypass, 1 doubled, 2 doubled with scanlines
   task automatic run_mode(input int mode);
      @(posedge sysclk);
      checks_on        <= 1'b0;
      vga_enable       <= (mode != 0);
      scanlines_enable <= (mode == 2);
      // Let the output settle on the new mode
      wait_vsync_falls(2);
      checks_on <= 1'b1;
      wait_vsync_falls(3);
      checks_on <= 1'b0;
   endtask

   // which 0 flash, 1 SD, otherwise both
   task automatic pulse_select(input int which, input int low_len, input int gap);
      @(posedge sysclk);
      flash_cs_n <= (which == 1);
      sd_cs_n    <= (which == 0);
      repeat (low_len) @(posedge sysclk);
      flash_cs_n <= 1'b1;
      sd_cs_n    <= 1'b1;
      repeat (gap) @(posedge sysclk);
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // Checking
   ///////////////////////////////////////////////////////////////////////////

   // Encoder pins fixed to PAL
   assert property (@(posedge sysclk) (stdn == 1'b0) && (stdnb == 1'b1))
      else fail_value("standard pins", 1, int'({stdn, stdnb}));

   always @(posedge sysclk) begin : check_outputs
      logic       hs_fall;
      logic       vs_fall;
      logic       exp_led;
      logic [8:0] exp_pix;
      int         h_period;
      int         h_low;
      string      mode_name;
      hs_fall   = hs_q && !hsync;
      vs_fall   = vs_q && !vsync;
      h_period  = vga_enable ? LINE_CYCLES / 2 : LINE_CYCLES;
      h_low     = vga_enable ? H_SYNC * PIX_DIV / 2 : H_SYNC * PIX_DIV;
      mode_name = vga_enable ? "doubled" : "bypass";
      // Outputs inactive while reset is held
      if (reset_d) begin
         assert (hsync && vsync) else fail_value("reset syncs", 3, int'({hsync, vsync}));
         assert ({r, g, b} == 9'd0) else fail_value("reset rgb", 0, int'({r, g, b}));
         assert (!testled) else fail_value("reset testled", 0, int'(testled));
      end
      if (!checks_on) begin
         h_armed  = 1'b0;
         hl_armed = 1'b0;
         v_armed  = 1'b0;
         vl_armed = 1'b0;
         locked   = 1'b0;
      end
      hper++;
      vper++;
      cyc++;
      if (!hsync) begin
         hlow++;
      end
      if (!vsync) begin
         vlow++;
      end
      // Line rate and sync width
      if (hs_fall) begin
         if (h_armed) begin
            assert (hper == h_period)
               else fail_value({mode_name, " hsync period"}, h_period, hper);
         end
         h_armed  = checks_on;
         hl_armed = checks_on;
         hper     = 0;
         hlow     = 1;
         cyc      = 0;
      end else if (!hs_q && hsync && hl_armed) begin
         assert (hlow == h_low) else fail_value({mode_name, " hsync low"}, h_low, hlow);
      end
      // Frame rate is the same in both modes
      if (vs_fall) begin
         if (v_armed) begin
            assert (vper == FRAME_CYCLES)
               else fail_value({mode_name, " vsync period"}, FRAME_CYCLES, vper);
         end
         v_armed  = checks_on;
         vl_armed = checks_on;
         vper     = 0;
         vlow     = 1;
         line     = VS_LINE;
         pass     = 0;
         locked   = checks_on;
      end else if (!vs_q && vsync && vl_armed) begin
         assert (vlow == V_SYNC * LINE_CYCLES)
            else fail_value({mode_name, " vsync low"}, V_SYNC * LINE_CYCLES, vlow);
      end
      // Doubled mode shows each line twice
      if (hs_fall && !vs_fall) begin
         if (vga_enable && pass == 0) begin
            pass = 1;
         end else begin
            pass = 0;
            line = (line + 1) % V_TOTAL;
         end
      end
      if (locked) begin
         exp_pix = expected_pixel((HS_COL + cyc / (h_period / H_TOTAL)) % H_TOTAL, line,
                                  vga_enable && scanlines_enable && pass == 1);
         pixel_checks++;
         assert ({r, g, b} == exp_pix)
            else fail_value($sformatf("%s pixel line %0d pass %0d", mode_name, line, pass),
                            int'(exp_pix), int'({r, g, b}));
      end
      // Activity LED against a monostable reference
      exp_led = (idle_cnt < LED_TIME);
      if (!reset_d && !reset) begin
         assert (testled == exp_led) else fail_value("activity led", int'(exp_led),
                                                    int'(testled));
      end
      if (reset) begin
         idle_cnt = IDLE_MAX;
      end else if (!flash_cs_n || !sd_cs_n) begin
         idle_cnt = 0;
      end else if (idle_cnt < IDLE_MAX) begin
         idle_cnt++;
      end
      reset_d = reset;
      hs_q    = hsync;
      vs_q    = vsync;
   end

   ///////////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////////

   initial begin
      int first;
      int which;
      int low_len;
      int gap;
      reset            <= 1'b1;
      vga_enable       <= 1'b0;
      scanlines_enable <= 1'b0;
      flash_cs_n       <= 1'b1;
      sd_cs_n          <= 1'b1;
      repeat (5) @(posedge sysclk);
      reset <= 1'b0;
      // Two rounds over all modes in a rotated order
      for (int round = 0; round < 2; round++) begin
         random_bits(2, first);
         for (int k = 0; k < 3; k++) begin
            run_mode((first + k) % 3);
         end
      end
      // Chip-select bursts, some gaps shorter than the stretch
      for (int i = 0; i < 12; i++) begin
         random_bits(2, which);
         random_bits(3, low_len);
         random_bits(5, gap);
         pulse_select(which, low_len + 1, gap + 1);
      end
      wait_led_off();
      repeat (LED_TIME) @(posedge sysclk);
      if (pixel_checks > 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         fail_text("no pixel was ever compared");
      end
   end

endmodule

/* flist.f */
rtl/video_pkg.sv
rtl/board_pkg.sv
rtl/video_if.sv
rtl/clock_enables.sv
rtl/pal_video_source.sv
rtl/vga_scandoubler.sv
rtl/activity_led.sv
rtl/tld_zxuno.sv
verification/tb_tld_zxuno.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_tld_zxuno
RTL_TOP    := tld_zxuno
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
